// File: source/mipsIsaPkg.sv
package mipsIsaPkg;

	typedef logic [31:0] instr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// Major opcodes, bits 31:26
	localparam opcode_t opRType = 6'b000000;
	localparam opcode_t opJ     = 6'b000010;
	localparam opcode_t opJal   = 6'b000011;
	localparam opcode_t opBeq   = 6'b000100;
	localparam opcode_t opBne   = 6'b000101;
	localparam opcode_t opAddi  = 6'b001000;
	localparam opcode_t opAddiu = 6'b001001;
	localparam opcode_t opSlti  = 6'b001010;
	localparam opcode_t opSltiu = 6'b001011;
	localparam opcode_t opAndi  = 6'b001100;
	localparam opcode_t opOri   = 6'b001101;
	localparam opcode_t opXori  = 6'b001110;
	localparam opcode_t opLui   = 6'b001111;
	localparam opcode_t opLw    = 6'b100011;
	localparam opcode_t opSw    = 6'b101011;

	// R-type function field, bits 5:0
	localparam funct_t fnSll  = 6'b000000;
	localparam funct_t fnSrl  = 6'b000010;
	localparam funct_t fnSra  = 6'b000011;
	localparam funct_t fnJr   = 6'b001000;
	localparam funct_t fnJalr = 6'b001001;
	localparam funct_t fnAdd  = 6'b100000;
	localparam funct_t fnAddu = 6'b100001;
	localparam funct_t fnSub  = 6'b100010;
	localparam funct_t fnSubu = 6'b100011;
	localparam funct_t fnAnd  = 6'b100100;
	localparam funct_t fnOr   = 6'b100101;
	localparam funct_t fnXor  = 6'b100110;
	localparam funct_t fnNor  = 6'b100111;
	localparam funct_t fnSlt  = 6'b101010;
	localparam funct_t fnSltu = 6'b101011;

	// Codes as the ALU in the datapath expects them
	typedef enum logic [3:0] {
		aluAnd  = 4'b0000,
		aluOr   = 4'b0001,
		aluAdd  = 4'b0010,
		aluXor  = 4'b0011,
		aluNor  = 4'b0100,
		aluSrl  = 4'b0101,
		aluSub  = 4'b0110,
		aluSlt  = 4'b0111,
		aluSll  = 4'b1000,
		aluAddu = 4'b1001,
		aluSubu = 4'b1010,
		aluSltu = 4'b1011,
		aluSra  = 4'b1110
	} aluOp_t;

	typedef enum logic [3:0] {
		clsRType, clsIType, clsLoad, clsStore, clsBranch, clsJump,
		clsJal, clsJr, clsJalr, clsLui, clsIllegal
	} instrClass_t;

endpackage

// File: source/ctrlSignalPkg.sv
package ctrlSignalPkg;

	// FSM state encoding
	typedef enum logic [4:0] {
		stFetch    = 5'b00000,
		stDecode   = 5'b00001,
		stExR      = 5'b00010,
		stExMem    = 5'b00011,
		stExI      = 5'b00100,
		stWbLui    = 5'b00101,
		stExBranch = 5'b00110,
		stExJr     = 5'b01000,
		stExJal    = 5'b01001,
		stExJump   = 5'b01010,
		stMemRead  = 5'b01011,
		stMemWrite = 5'b01100,
		stWbR      = 5'b01101,
		stWbI      = 5'b01110,
		stWbLoad   = 5'b01111,
		stError    = 5'b11111
	} ctrlState_t;

	// Register file write data select
	typedef logic [1:0] memToReg_t;
	localparam memToReg_t mtrAlu = 2'd0;
	localparam memToReg_t mtrMem = 2'd1;
	localparam memToReg_t mtrLui = 2'd2;
	localparam memToReg_t mtrPc  = 2'd3;

	typedef logic [1:0] pcSource_t;
	localparam pcSource_t pcsAlu    = 2'd0; // PC + 4 straight from the ALU
	localparam pcSource_t pcsAluOut = 2'd1; // Registered branch target
	localparam pcSource_t pcsJump   = 2'd2;
	localparam pcSource_t pcsReg    = 2'd3;

	typedef logic [1:0] aluSrcB_t;
	localparam aluSrcB_t srcBReg      = 2'd0;
	localparam aluSrcB_t srcBFour     = 2'd1;
	localparam aluSrcB_t srcBImm      = 2'd2;
	localparam aluSrcB_t srcBImmShift = 2'd3;

	typedef logic [1:0] regDst_t;
	localparam regDst_t dstRt = 2'd0;
	localparam regDst_t dstRd = 2'd1;
	localparam regDst_t dstRa = 2'd2; // $31 for jal

endpackage

// File: source/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
	input  mipsIsaPkg::instr_t      inst_i,
	output mipsIsaPkg::instrClass_t instrClass_o,
	output mipsIsaPkg::aluOp_t      aluOp_o,
	output logic                    zeroExt_o
);

	mipsIsaPkg::opcode_t opcode;
	mipsIsaPkg::funct_t  funct;

	assign opcode = inst_i[31:26];
	assign funct  = inst_i[5:0];

	always_comb begin
		instrClass_o = mipsIsaPkg::clsIllegal;
		aluOp_o      = mipsIsaPkg::aluAdd; // Address and immediate add
		zeroExt_o    = 1'b0;
		case (opcode)
			mipsIsaPkg::opRType: begin
				instrClass_o = mipsIsaPkg::clsRType;
				case (funct)
					mipsIsaPkg::fnAdd:  aluOp_o = mipsIsaPkg::aluAdd;
					mipsIsaPkg::fnSub:  aluOp_o = mipsIsaPkg::aluSub;
					mipsIsaPkg::fnAnd:  aluOp_o = mipsIsaPkg::aluAnd;
					mipsIsaPkg::fnOr:   aluOp_o = mipsIsaPkg::aluOr;
					mipsIsaPkg::fnXor:  aluOp_o = mipsIsaPkg::aluXor;
					mipsIsaPkg::fnNor:  aluOp_o = mipsIsaPkg::aluNor;
					mipsIsaPkg::fnSlt:  aluOp_o = mipsIsaPkg::aluSlt;
					mipsIsaPkg::fnSrl:  aluOp_o = mipsIsaPkg::aluSrl;
					mipsIsaPkg::fnSll:  aluOp_o = mipsIsaPkg::aluSll;
					mipsIsaPkg::fnAddu: aluOp_o = mipsIsaPkg::aluAddu;
					mipsIsaPkg::fnSubu: aluOp_o = mipsIsaPkg::aluSubu;
					mipsIsaPkg::fnSltu: aluOp_o = mipsIsaPkg::aluSltu;
					mipsIsaPkg::fnSra:  aluOp_o = mipsIsaPkg::aluSra;
					mipsIsaPkg::fnJr:   instrClass_o = mipsIsaPkg::clsJr;
					mipsIsaPkg::fnJalr: instrClass_o = mipsIsaPkg::clsJalr;
					default:            instrClass_o = mipsIsaPkg::clsIllegal;
				endcase
			end
			mipsIsaPkg::opLw: instrClass_o = mipsIsaPkg::clsLoad;
			mipsIsaPkg::opSw: instrClass_o = mipsIsaPkg::clsStore;
			mipsIsaPkg::opBeq, mipsIsaPkg::opBne: begin
				instrClass_o = mipsIsaPkg::clsBranch;
				aluOp_o      = mipsIsaPkg::aluSub; // Compare rs with rt
				// Extension is unused by a branch, the flag marks bne instead
				zeroExt_o    = (opcode == mipsIsaPkg::opBne);
			end
			mipsIsaPkg::opJ:   instrClass_o = mipsIsaPkg::clsJump;
			mipsIsaPkg::opJal: instrClass_o = mipsIsaPkg::clsJal;
			mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu: instrClass_o = mipsIsaPkg::clsIType;
			mipsIsaPkg::opSlti: begin
				instrClass_o = mipsIsaPkg::clsIType;
				aluOp_o      = mipsIsaPkg::aluSlt;
			end
			mipsIsaPkg::opSltiu: begin
				instrClass_o = mipsIsaPkg::clsIType;
				aluOp_o      = mipsIsaPkg::aluSltu;
				zeroExt_o    = 1'b1;
			end
			mipsIsaPkg::opAndi, mipsIsaPkg::opOri, mipsIsaPkg::opXori: begin
				instrClass_o = mipsIsaPkg::clsIType;
				zeroExt_o    = 1'b1; // Logical immediates are unsigned
				if (opcode == mipsIsaPkg::opAndi)
					aluOp_o = mipsIsaPkg::aluAnd;
				else if (opcode == mipsIsaPkg::opOri)
					aluOp_o = mipsIsaPkg::aluOr;
				else
					aluOp_o = mipsIsaPkg::aluXor;
			end
			mipsIsaPkg::opLui: instrClass_o = mipsIsaPkg::clsLui;
			default:           instrClass_o = mipsIsaPkg::clsIllegal;
		endcase
	end

endmodule

// File: source/stateSequencer.sv
`timescale 1ns/1ps

module stateSequencer (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    mioReady_i,
	input  mipsIsaPkg::instrClass_t instrClass_i,
	input  mipsIsaPkg::aluOp_t      aluOp_i,
	input  logic                    zeroExt_i,
	output ctrlSignalPkg::ctrlState_t state_o,
	output mipsIsaPkg::aluOp_t      aluOperation_o,
	output logic                    zeroExtend_o,
	output logic                    branchOnEqual_o
);

	ctrlSignalPkg::ctrlState_t state;
	ctrlSignalPkg::ctrlState_t stateNext;

	assign state_o = state;

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////
	always_comb begin
		stateNext = ctrlSignalPkg::stError;
		case (state)
			ctrlSignalPkg::stFetch:
				stateNext = mioReady_i ? ctrlSignalPkg::stDecode : ctrlSignalPkg::stFetch;
			ctrlSignalPkg::stDecode: begin
				case (instrClass_i)
					mipsIsaPkg::clsRType:  stateNext = ctrlSignalPkg::stExR;
					mipsIsaPkg::clsIType:  stateNext = ctrlSignalPkg::stExI;
					mipsIsaPkg::clsLoad,
					mipsIsaPkg::clsStore:  stateNext = ctrlSignalPkg::stExMem;
					mipsIsaPkg::clsBranch: stateNext = ctrlSignalPkg::stExBranch;
					mipsIsaPkg::clsJump:   stateNext = ctrlSignalPkg::stExJump;
					mipsIsaPkg::clsJr:     stateNext = ctrlSignalPkg::stExJr;
					mipsIsaPkg::clsJal,
					mipsIsaPkg::clsJalr:   stateNext = ctrlSignalPkg::stExJal;
					mipsIsaPkg::clsLui:    stateNext = ctrlSignalPkg::stWbLui;
					default:               stateNext = ctrlSignalPkg::stError;
				endcase
			end
			ctrlSignalPkg::stExR: stateNext = ctrlSignalPkg::stWbR;
			ctrlSignalPkg::stExI: stateNext = ctrlSignalPkg::stWbI;
			// Instruction word is still stable here
			ctrlSignalPkg::stExMem:
				stateNext = (instrClass_i == mipsIsaPkg::clsLoad) ?
					ctrlSignalPkg::stMemRead : ctrlSignalPkg::stMemWrite;
			ctrlSignalPkg::stMemRead:
				stateNext = mioReady_i ? ctrlSignalPkg::stWbLoad : ctrlSignalPkg::stMemRead;
			ctrlSignalPkg::stMemWrite:
				stateNext = mioReady_i ? ctrlSignalPkg::stFetch : ctrlSignalPkg::stMemWrite;
			ctrlSignalPkg::stWbR, ctrlSignalPkg::stWbI, ctrlSignalPkg::stWbLoad,
			ctrlSignalPkg::stWbLui, ctrlSignalPkg::stExBranch, ctrlSignalPkg::stExJump,
			ctrlSignalPkg::stExJr, ctrlSignalPkg::stExJal:
				stateNext = ctrlSignalPkg::stFetch;
			default: stateNext = ctrlSignalPkg::stError; // Sticky until reset
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state           <= ctrlSignalPkg::stFetch;
			aluOperation_o  <= mipsIsaPkg::aluAdd;
			zeroExtend_o    <= 1'b0;
			branchOnEqual_o <= 1'b0;
		end else begin
			state <= stateNext;
			if (state == ctrlSignalPkg::stDecode) begin
				aluOperation_o  <= aluOp_i;
				zeroExtend_o    <= (instrClass_i == mipsIsaPkg::clsIType) && zeroExt_i;
				branchOnEqual_o <= (instrClass_i == mipsIsaPkg::clsBranch) && !zeroExt_i;
			end else if (stateNext == ctrlSignalPkg::stFetch) begin
				aluOperation_o <= mipsIsaPkg::aluAdd; // PC + 4 in the coming fetch
				zeroExtend_o   <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////
	errorSticky: assert property (@(posedge clk) disable iff (reset)
		state == ctrlSignalPkg::stError |=> state == ctrlSignalPkg::stError);

	decodeOneCycle: assert property (@(posedge clk) disable iff (reset)
		state == ctrlSignalPkg::stDecode |=> state != ctrlSignalPkg::stDecode);

	stateLegal: assert property (@(posedge clk) disable iff (reset)
		state inside {ctrlSignalPkg::stFetch, ctrlSignalPkg::stDecode, ctrlSignalPkg::stExR,
			ctrlSignalPkg::stExMem, ctrlSignalPkg::stExI, ctrlSignalPkg::stWbLui,
			ctrlSignalPkg::stExBranch, ctrlSignalPkg::stExJr, ctrlSignalPkg::stExJal,
			ctrlSignalPkg::stExJump, ctrlSignalPkg::stMemRead, ctrlSignalPkg::stMemWrite,
			ctrlSignalPkg::stWbR, ctrlSignalPkg::stWbI, ctrlSignalPkg::stWbLoad,
			ctrlSignalPkg::stError});

endmodule

// File: source/controlWordGen.sv
`timescale 1ns/1ps

module controlWordGen (
	input  ctrlSignalPkg::ctrlState_t state_i,
	input  logic                      mioReady_i,
	output logic                      pcWrite_o,
	output logic                      pcWriteCond_o,
	output logic                      iorD_o,
	output logic                      memRead_o,
	output logic                      memWrite_o,
	output logic                      irWrite_o,
	output logic                      regWrite_o,
	output logic                      cpuMio_o,
	output logic                      aluSrcA_o,
	output ctrlSignalPkg::memToReg_t  memToReg_o,
	output ctrlSignalPkg::pcSource_t  pcSource_o,
	output ctrlSignalPkg::aluSrcB_t   aluSrcB_o,
	output ctrlSignalPkg::regDst_t    regDst_o
);

	always_comb begin
		pcWrite_o     = 1'b0;
		pcWriteCond_o = 1'b0;
		iorD_o        = 1'b0;
		memRead_o     = 1'b0;
		memWrite_o    = 1'b0;
		irWrite_o     = 1'b0;
		regWrite_o    = 1'b0;
		cpuMio_o      = 1'b0;
		aluSrcA_o     = 1'b0; // PC on ALU port A
		memToReg_o    = ctrlSignalPkg::mtrAlu;
		pcSource_o    = ctrlSignalPkg::pcsAlu;
		aluSrcB_o     = ctrlSignalPkg::srcBReg;
		regDst_o      = ctrlSignalPkg::dstRt;
		case (state_i)
			ctrlSignalPkg::stFetch: begin
				memRead_o = 1'b1;
				cpuMio_o  = 1'b1;
				aluSrcB_o = ctrlSignalPkg::srcBFour;
				pcWrite_o = mioReady_i; // PC and IR move together once the word is there
				irWrite_o = mioReady_i;
			end
			// Branch target is formed while the opcode is decoded
			ctrlSignalPkg::stDecode: aluSrcB_o = ctrlSignalPkg::srcBImmShift;
			ctrlSignalPkg::stExR: aluSrcA_o = 1'b1;
			ctrlSignalPkg::stExI, ctrlSignalPkg::stExMem: begin
				aluSrcA_o = 1'b1;
				aluSrcB_o = ctrlSignalPkg::srcBImm;
			end
			ctrlSignalPkg::stMemRead: begin
				memRead_o = 1'b1;
				iorD_o    = 1'b1;
				cpuMio_o  = 1'b1;
			end
			ctrlSignalPkg::stMemWrite: begin
				memWrite_o = mioReady_i;
				iorD_o     = 1'b1;
				cpuMio_o   = 1'b1;
			end
			ctrlSignalPkg::stWbR: begin
				regWrite_o = 1'b1;
				regDst_o   = ctrlSignalPkg::dstRd;
			end
			ctrlSignalPkg::stWbI: regWrite_o = 1'b1;
			ctrlSignalPkg::stWbLoad: begin
				regWrite_o = 1'b1;
				memToReg_o = ctrlSignalPkg::mtrMem;
			end
			ctrlSignalPkg::stWbLui: begin
				regWrite_o = 1'b1;
				memToReg_o = ctrlSignalPkg::mtrLui;
			end
			ctrlSignalPkg::stExBranch: begin
				pcWriteCond_o = 1'b1; // Datapath gates this with zero and the branch sense
				aluSrcA_o     = 1'b1;
				pcSource_o    = ctrlSignalPkg::pcsAluOut;
			end
			ctrlSignalPkg::stExJump: begin
				pcWrite_o  = 1'b1;
				pcSource_o = ctrlSignalPkg::pcsJump;
			end
			ctrlSignalPkg::stExJr: begin
				pcWrite_o  = 1'b1;
				aluSrcA_o  = 1'b1;
				pcSource_o = ctrlSignalPkg::pcsReg;
			end
			ctrlSignalPkg::stExJal: begin
				pcWrite_o  = 1'b1;
				regWrite_o = 1'b1;
				memToReg_o = ctrlSignalPkg::mtrPc; // Link address
				regDst_o   = ctrlSignalPkg::dstRa;
				pcSource_o = ctrlSignalPkg::pcsJump;
			end
			default: ; // Error state keeps everything quiet
		endcase
	end

	always_comb begin
		memAccessExclusive: assert (!(memRead_o && memWrite_o))
			else $error("memRead and memWrite both high in state %0d", state_i);
	end

endmodule

// File: source/mipsControl.sv
`timescale 1ns/1ps

module mipsControl (
	input  logic                      clk,
	input  logic                      reset,
	input  mipsIsaPkg::instr_t        inst_i,
	input  logic                      mioReady_i,
	output logic                      pcWrite_o,
	output logic                      pcWriteCond_o,
	output logic                      iorD_o,
	output logic                      memRead_o,
	output logic                      memWrite_o,
	output logic                      irWrite_o,
	output logic                      regWrite_o,
	output logic                      cpuMio_o,
	output logic                      aluSrcA_o,
	output ctrlSignalPkg::memToReg_t  memToReg_o,
	output ctrlSignalPkg::pcSource_t  pcSource_o,
	output ctrlSignalPkg::aluSrcB_t   aluSrcB_o,
	output ctrlSignalPkg::regDst_t    regDst_o,
	output mipsIsaPkg::aluOp_t        aluOperation_o,
	output logic                      zeroExtend_o,
	output logic                      branchOnEqual_o,
	output ctrlSignalPkg::ctrlState_t stateOut_o
);

	mipsIsaPkg::instrClass_t   instrClass;
	mipsIsaPkg::aluOp_t        decodedAluOp;
	logic                      decodedZeroExt;
	ctrlSignalPkg::ctrlState_t state;

	assign stateOut_o = state;

	// Pure decode of the held instruction word
	instrDecoder decoder_i (
		.inst_i       (inst_i),
		.instrClass_o (instrClass),
		.aluOp_o      (decodedAluOp),
		.zeroExt_o    (decodedZeroExt)
	);

	stateSequencer sequencer_i (
		.clk             (clk),
		.reset           (reset),
		.mioReady_i      (mioReady_i),
		.instrClass_i    (instrClass),
		.aluOp_i         (decodedAluOp),
		.zeroExt_i       (decodedZeroExt),
		.state_o         (state),
		.aluOperation_o  (aluOperation_o),
		.zeroExtend_o    (zeroExtend_o),
		.branchOnEqual_o (branchOnEqual_o)
	);

	controlWordGen wordGen_i (
		.state_i       (state),
		.mioReady_i    (mioReady_i),
		.pcWrite_o     (pcWrite_o),
		.pcWriteCond_o (pcWriteCond_o),
		.iorD_o        (iorD_o),
		.memRead_o     (memRead_o),
		.memWrite_o    (memWrite_o),
		.irWrite_o     (irWrite_o),
		.regWrite_o    (regWrite_o),
		.cpuMio_o      (cpuMio_o),
		.aluSrcA_o     (aluSrcA_o),
		.memToReg_o    (memToReg_o),
		.pcSource_o    (pcSource_o),
		.aluSrcB_o     (aluSrcB_o),
		.regDst_o      (regDst_o)
	);

endmodule

// File: verification/ctrlChecker.sv
`timescale 1ns/1ps

module ctrlChecker (
	input  logic                      clk,
	input  logic                      reset,
	input  mipsIsaPkg::instr_t        inst_i,
	input  logic                      mioReady_i,
	input  ctrlSignalPkg::ctrlState_t stateOut_i,
	input  logic                      memRead_i,
	input  logic                      memWrite_i,
	input  logic                      regWrite_i,
	input  logic                      pcWrite_i,
	input  logic                      pcWriteCond_i,
	input  logic                      irWrite_i,
	input  logic                      iorD_i,
	input  logic                      cpuMio_i,
	input  logic                      aluSrcA_i,
	input  ctrlSignalPkg::aluSrcB_t   aluSrcB_i,
	input  ctrlSignalPkg::pcSource_t  pcSource_i,
	input  ctrlSignalPkg::regDst_t    regDst_i,
	input  ctrlSignalPkg::memToReg_t  memToReg_i,
	input  mipsIsaPkg::aluOp_t        aluOperation_i,
	input  logic                      zeroExtend_i,
	input  logic                      branchOnEqual_i,
	output int                        errorCount_o
);

	ctrlSignalPkg::ctrlState_t modelState;
	mipsIsaPkg::aluOp_t        expAlu;
	logic                      expZext;
	logic                      expBeq;
	// memRead, memWrite, regWrite, pcWrite, pcWriteCond, irWrite, iorD, cpuMio
	logic [7:0]                strobeExp;
	logic [3:0]                selExp;    // regDst, memToReg
	logic [2:0]                aluSrcExp; // aluSrcA, aluSrcB
	int                        errors = 0;

	assign errorCount_o = errors;

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic ctrlSignalPkg::ctrlState_t modelNext(
		input ctrlSignalPkg::ctrlState_t st,
		input mipsIsaPkg::instr_t inst,
		input logic rdy
	);
		mipsIsaPkg::opcode_t       op;
		mipsIsaPkg::funct_t        fn;
		ctrlSignalPkg::ctrlState_t nx;
		op = inst[31:26];
		fn = inst[5:0];
		nx = ctrlSignalPkg::stFetch; // One-cycle execute and write-back states
		case (st)
			ctrlSignalPkg::stFetch: begin
				if (rdy)
					nx = ctrlSignalPkg::stDecode;
				else
					nx = ctrlSignalPkg::stFetch;
			end
			ctrlSignalPkg::stDecode: begin
				if (op == mipsIsaPkg::opRType && fn == mipsIsaPkg::fnJr)
					nx = ctrlSignalPkg::stExJr;
				else if ((op == mipsIsaPkg::opRType && fn == mipsIsaPkg::fnJalr) ||
						op == mipsIsaPkg::opJal)
					nx = ctrlSignalPkg::stExJal;
				else if (op == mipsIsaPkg::opRType && fn inside {mipsIsaPkg::fnAdd,
						mipsIsaPkg::fnSub, mipsIsaPkg::fnAnd, mipsIsaPkg::fnOr,
						mipsIsaPkg::fnXor, mipsIsaPkg::fnNor, mipsIsaPkg::fnSlt,
						mipsIsaPkg::fnSrl, mipsIsaPkg::fnSll, mipsIsaPkg::fnAddu,
						mipsIsaPkg::fnSubu, mipsIsaPkg::fnSltu, mipsIsaPkg::fnSra})
					nx = ctrlSignalPkg::stExR;
				else if (op == mipsIsaPkg::opLw || op == mipsIsaPkg::opSw)
					nx = ctrlSignalPkg::stExMem;
				else if (op == mipsIsaPkg::opBeq || op == mipsIsaPkg::opBne)
					nx = ctrlSignalPkg::stExBranch;
				else if (op == mipsIsaPkg::opJ)
					nx = ctrlSignalPkg::stExJump;
				else if (op == mipsIsaPkg::opLui)
					nx = ctrlSignalPkg::stWbLui;
				else if (op inside {mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu,
						mipsIsaPkg::opAndi, mipsIsaPkg::opOri, mipsIsaPkg::opXori,
						mipsIsaPkg::opSlti, mipsIsaPkg::opSltiu})
					nx = ctrlSignalPkg::stExI;
				else
					nx = ctrlSignalPkg::stError; // Unknown opcode or function code
			end
			ctrlSignalPkg::stExR: nx = ctrlSignalPkg::stWbR;
			ctrlSignalPkg::stExI: nx = ctrlSignalPkg::stWbI;
			ctrlSignalPkg::stExMem: begin
				if (op == mipsIsaPkg::opLw)
					nx = ctrlSignalPkg::stMemRead;
				else
					nx = ctrlSignalPkg::stMemWrite;
			end
			ctrlSignalPkg::stMemRead: begin
				if (rdy)
					nx = ctrlSignalPkg::stWbLoad;
				else
					nx = ctrlSignalPkg::stMemRead;
			end
			ctrlSignalPkg::stMemWrite: begin
				if (!rdy)
					nx = ctrlSignalPkg::stMemWrite;
			end
			ctrlSignalPkg::stError: nx = ctrlSignalPkg::stError;
			default: nx = ctrlSignalPkg::stFetch;
		endcase
		return nx;
	endfunction

	function automatic mipsIsaPkg::aluOp_t expectAlu(input mipsIsaPkg::instr_t inst);
		mipsIsaPkg::aluOp_t r;
		r = mipsIsaPkg::aluAdd; // addi, addiu
		if (inst[31:26] == mipsIsaPkg::opRType) begin
			case (inst[5:0])
				mipsIsaPkg::fnSub:  r = mipsIsaPkg::aluSub;
				mipsIsaPkg::fnAnd:  r = mipsIsaPkg::aluAnd;
				mipsIsaPkg::fnOr:   r = mipsIsaPkg::aluOr;
				mipsIsaPkg::fnXor:  r = mipsIsaPkg::aluXor;
				mipsIsaPkg::fnNor:  r = mipsIsaPkg::aluNor;
				mipsIsaPkg::fnSlt:  r = mipsIsaPkg::aluSlt;
				mipsIsaPkg::fnSrl:  r = mipsIsaPkg::aluSrl;
				mipsIsaPkg::fnSll:  r = mipsIsaPkg::aluSll;
				mipsIsaPkg::fnAddu: r = mipsIsaPkg::aluAddu;
				mipsIsaPkg::fnSubu: r = mipsIsaPkg::aluSubu;
				mipsIsaPkg::fnSltu: r = mipsIsaPkg::aluSltu;
				mipsIsaPkg::fnSra:  r = mipsIsaPkg::aluSra;
				default:            r = mipsIsaPkg::aluAdd;
			endcase
		end else begin
			case (inst[31:26])
				mipsIsaPkg::opAndi:  r = mipsIsaPkg::aluAnd;
				mipsIsaPkg::opOri:   r = mipsIsaPkg::aluOr;
				mipsIsaPkg::opXori:  r = mipsIsaPkg::aluXor;
				mipsIsaPkg::opSlti:  r = mipsIsaPkg::aluSlt;
				mipsIsaPkg::opSltiu: r = mipsIsaPkg::aluSltu;
				default:             r = mipsIsaPkg::aluAdd;
			endcase
		end
		return r;
	endfunction

	// Strobe table per state
	function automatic logic [7:0] expStrobes(
		input ctrlSignalPkg::ctrlState_t st,
		input logic rdy
	);
		logic [7:0] s;
		case (st)
			ctrlSignalPkg::stFetch:
				s = {1'b1, 1'b0, 1'b0, rdy, 1'b0, rdy, 1'b0, 1'b1};
			ctrlSignalPkg::stMemRead:  s = 8'b1000_0011;
			ctrlSignalPkg::stMemWrite: s = {1'b0, rdy, 4'b0000, 2'b11};
			ctrlSignalPkg::stWbR, ctrlSignalPkg::stWbI,
			ctrlSignalPkg::stWbLoad, ctrlSignalPkg::stWbLui: s = 8'b0010_0000;
			ctrlSignalPkg::stExBranch: s = 8'b0000_1000;
			ctrlSignalPkg::stExJump, ctrlSignalPkg::stExJr: s = 8'b0001_0000;
			ctrlSignalPkg::stExJal:    s = 8'b0011_0000; // Link write and jump together
			default:                   s = 8'b0000_0000;
		endcase
		return s;
	endfunction

	function automatic logic [3:0] expSelects(input ctrlSignalPkg::ctrlState_t st);
		logic [3:0] s;
		case (st)
			ctrlSignalPkg::stWbR:    s = {ctrlSignalPkg::dstRd, ctrlSignalPkg::mtrAlu};
			ctrlSignalPkg::stWbLoad: s = {ctrlSignalPkg::dstRt, ctrlSignalPkg::mtrMem};
			ctrlSignalPkg::stWbLui:  s = {ctrlSignalPkg::dstRt, ctrlSignalPkg::mtrLui};
			ctrlSignalPkg::stExJal:  s = {ctrlSignalPkg::dstRa, ctrlSignalPkg::mtrPc};
			default:                 s = {ctrlSignalPkg::dstRt, ctrlSignalPkg::mtrAlu};
		endcase
		return s;
	endfunction

	// ALU inputs in the states whose ALU result is used
	function automatic logic [2:0] aluSources(input ctrlSignalPkg::ctrlState_t st);
		logic [2:0] s;
		case (st)
			ctrlSignalPkg::stFetch:  s = {1'b0, ctrlSignalPkg::srcBFour};
			ctrlSignalPkg::stDecode: s = {1'b0, ctrlSignalPkg::srcBImmShift}; // Branch target
			ctrlSignalPkg::stExR, ctrlSignalPkg::stExBranch:
				s = {1'b1, ctrlSignalPkg::srcBReg};
			default: s = {1'b1, ctrlSignalPkg::srcBImm}; // Immediate ops and address
		endcase
		return s;
	endfunction

	// Next PC source in the states that write the PC
	function automatic ctrlSignalPkg::pcSource_t pcSourceFor(
		input ctrlSignalPkg::ctrlState_t st
	);
		ctrlSignalPkg::pcSource_t s;
		case (st)
			ctrlSignalPkg::stFetch:    s = ctrlSignalPkg::pcsAlu;
			ctrlSignalPkg::stExBranch: s = ctrlSignalPkg::pcsAluOut;
			ctrlSignalPkg::stExJump:   s = ctrlSignalPkg::pcsJump;
			default:                   s = ctrlSignalPkg::pcsReg;
		endcase
		return s;
	endfunction

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			modelState <= ctrlSignalPkg::stFetch;
		end else begin
			if (modelState == ctrlSignalPkg::stDecode) begin // Latched with the decode edge
				expAlu  <= expectAlu(inst_i);
				expZext <= inst_i[31:26] inside {mipsIsaPkg::opAndi, mipsIsaPkg::opOri,
					mipsIsaPkg::opXori, mipsIsaPkg::opSltiu};
				expBeq  <= (inst_i[31:26] == mipsIsaPkg::opBeq);
			end
			modelState <= modelNext(modelState, inst_i, mioReady_i);
		end
	end

	////////////////////////////////////////////////////////////
	// Comparison at the falling edge
	////////////////////////////////////////////////////////////
	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("** Error at %0t: %s expected %0h, actual %0h", $time, name,
				expected, actual);
		end
	endtask

	always @(negedge clk) begin
		strobeExp = expStrobes(modelState, mioReady_i);
		checkValue("stateOut_o", 32'(modelState), 32'(stateOut_i));
		checkValue("memRead_o", 32'(strobeExp[7]), 32'(memRead_i));
		checkValue("memWrite_o", 32'(strobeExp[6]), 32'(memWrite_i));
		checkValue("regWrite_o", 32'(strobeExp[5]), 32'(regWrite_i));
		checkValue("pcWrite_o", 32'(strobeExp[4]), 32'(pcWrite_i));
		checkValue("pcWriteCond_o", 32'(strobeExp[3]), 32'(pcWriteCond_i));
		checkValue("irWrite_o", 32'(strobeExp[2]), 32'(irWrite_i));
		checkValue("iorD_o", 32'(strobeExp[1]), 32'(iorD_i));
		checkValue("cpuMio_o", 32'(strobeExp[0]), 32'(cpuMio_i));
		if (modelState inside {ctrlSignalPkg::stFetch, ctrlSignalPkg::stDecode,
				ctrlSignalPkg::stExR, ctrlSignalPkg::stExI, ctrlSignalPkg::stExMem,
				ctrlSignalPkg::stExBranch}) begin
			aluSrcExp = aluSources(modelState);
			checkValue("aluSrcA_o", 32'(aluSrcExp[2]), 32'(aluSrcA_i));
			checkValue("aluSrcB_o", 32'(aluSrcExp[1:0]), 32'(aluSrcB_i));
		end
		if (modelState inside {ctrlSignalPkg::stFetch, ctrlSignalPkg::stExBranch,
				ctrlSignalPkg::stExJump, ctrlSignalPkg::stExJr})
			checkValue("pcSource_o", 32'(pcSourceFor(modelState)), 32'(pcSource_i));
		if (modelState == ctrlSignalPkg::stExR || modelState == ctrlSignalPkg::stExI) begin
			checkValue("aluOperation_o", 32'(expAlu), 32'(aluOperation_i));
			checkValue("zeroExtend_o", 32'(expZext), 32'(zeroExtend_i));
		end
		if (modelState == ctrlSignalPkg::stFetch) // PC + 4
			checkValue("aluOperation_o", 32'(mipsIsaPkg::aluAdd), 32'(aluOperation_i));
		if (modelState == ctrlSignalPkg::stExBranch)
			checkValue("branchOnEqual_o", 32'(expBeq), 32'(branchOnEqual_i));
		if (modelState inside {ctrlSignalPkg::stWbR, ctrlSignalPkg::stWbI,
				ctrlSignalPkg::stWbLoad, ctrlSignalPkg::stWbLui,
				ctrlSignalPkg::stExJal}) begin
			selExp = expSelects(modelState);
			checkValue("regDst_o", 32'(selExp[3:2]), 32'(regDst_i));
			checkValue("memToReg_o", 32'(selExp[1:0]), 32'(memToReg_i));
		end
	end

endmodule

// File: verification/mipsControlTb.sv
`timescale 1ns/1ps

module mipsControlTb;

	logic                      clk;
	logic                      reset;
	mipsIsaPkg::instr_t        inst;
	logic                      mioReady;
	logic                      pcWrite;
	logic                      pcWriteCond;
	logic                      iorD;
	logic                      memRead;
	logic                      memWrite;
	logic                      irWrite;
	logic                      regWrite;
	logic                      cpuMio;
	logic                      aluSrcA;
	ctrlSignalPkg::memToReg_t  memToReg;
	ctrlSignalPkg::pcSource_t  pcSource;
	ctrlSignalPkg::aluSrcB_t   aluSrcB;
	ctrlSignalPkg::regDst_t    regDst;
	mipsIsaPkg::aluOp_t        aluOperation;
	logic                      zeroExtend;
	logic                      branchOnEqual;
	ctrlSignalPkg::ctrlState_t stateOut;
	logic [31:0]               lfsr;
	int                        mismatches;
	int                        timeouts;

	// Pools for the weighted instruction choice
	mipsIsaPkg::funct_t functPool [15] = '{mipsIsaPkg::fnAdd, mipsIsaPkg::fnSub,
		mipsIsaPkg::fnAnd, mipsIsaPkg::fnOr, mipsIsaPkg::fnXor, mipsIsaPkg::fnNor,
		mipsIsaPkg::fnSlt, mipsIsaPkg::fnSrl, mipsIsaPkg::fnSll, mipsIsaPkg::fnAddu,
		mipsIsaPkg::fnSubu, mipsIsaPkg::fnSltu, mipsIsaPkg::fnSra, mipsIsaPkg::fnJr,
		mipsIsaPkg::fnJalr};
	mipsIsaPkg::opcode_t immOpPool [8] = '{mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu,
		mipsIsaPkg::opAndi, mipsIsaPkg::opOri, mipsIsaPkg::opXori, mipsIsaPkg::opSlti,
		mipsIsaPkg::opSltiu, mipsIsaPkg::opLui};

	always #4 clk = ~clk;

	mipsControl dut_i (
		.clk             (clk),
		.reset           (reset),
		.inst_i          (inst),
		.mioReady_i      (mioReady),
		.pcWrite_o       (pcWrite),
		.pcWriteCond_o   (pcWriteCond),
		.iorD_o          (iorD),
		.memRead_o       (memRead),
		.memWrite_o      (memWrite),
		.irWrite_o       (irWrite),
		.regWrite_o      (regWrite),
		.cpuMio_o        (cpuMio),
		.aluSrcA_o       (aluSrcA),
		.memToReg_o      (memToReg),
		.pcSource_o      (pcSource),
		.aluSrcB_o       (aluSrcB),
		.regDst_o        (regDst),
		.aluOperation_o  (aluOperation),
		.zeroExtend_o    (zeroExtend),
		.branchOnEqual_o (branchOnEqual),
		.stateOut_o      (stateOut)
	);

	ctrlChecker checker_i (
		.clk             (clk),
		.reset           (reset),
		.inst_i          (inst),
		.mioReady_i      (mioReady),
		.stateOut_i      (stateOut),
		.memRead_i       (memRead),
		.memWrite_i      (memWrite),
		.regWrite_i      (regWrite),
		.pcWrite_i       (pcWrite),
		.pcWriteCond_i   (pcWriteCond),
		.irWrite_i       (irWrite),
		.iorD_i          (iorD),
		.cpuMio_i        (cpuMio),
		.aluSrcA_i       (aluSrcA),
		.aluSrcB_i       (aluSrcB),
		.pcSource_i      (pcSource),
		.regDst_i        (regDst),
		.memToReg_i      (memToReg),
		.aluOperation_i  (aluOperation),
		.zeroExtend_i    (zeroExtend),
		.branchOnEqual_i (branchOnEqual),
		.errorCount_o    (mismatches)
	);

	////////////////////////////////////////////////////////////
	// Random source
	////////////////////////////////////////////////////////////
	function automatic logic nextBit();
		logic fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // Taps 32, 22, 2, 1
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
			v = {v[30:0], nextBit()};
		return v;
	endfunction

	function automatic mipsIsaPkg::instr_t randomInstr();
		logic [31:0]         fields;
		logic [3:0]          pick;
		mipsIsaPkg::opcode_t op;
		mipsIsaPkg::instr_t  word;
		fields = randBits(26);
		pick   = 4'(randBits(4));
		// R-type 5 of 16, immediates 3, memory 4, branches 2, jumps 2
		case (pick)
			4'd0, 4'd1, 4'd2, 4'd3, 4'd4: op = mipsIsaPkg::opRType;
			4'd5, 4'd6, 4'd7: op = immOpPool[3'(randBits(3))];
			4'd8, 4'd9:       op = mipsIsaPkg::opLw;
			4'd10, 4'd11:     op = mipsIsaPkg::opSw;
			4'd12:            op = mipsIsaPkg::opBeq;
			4'd13:            op = mipsIsaPkg::opBne;
			4'd14:            op = mipsIsaPkg::opJ;
			default:          op = mipsIsaPkg::opJal;
		endcase
		word = {op, fields[25:0]};
		if (op == mipsIsaPkg::opRType)
			word[5:0] = functPool[4'(randBits(4) % 32'd15)];
		return word;
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	task automatic stepCycle();
		@(posedge clk);
		#1 mioReady = nextBit();
	endtask

	// With leave set, wait until the state differs from target
	task automatic waitState(input ctrlSignalPkg::ctrlState_t target, input logic leave,
			input int limit);
		int count;
		count = 0;
		while (((stateOut == target) == leave) && count < limit) begin
			stepCycle();
			count++;
		end
		if ((stateOut == target) == leave) begin
			timeouts++;
			$display("Timeout at %0t: state did not %s %s within %0d cycles", $time,
				leave ? "leave" : "reach", target.name(), limit);
		end
	endtask

	task automatic holdInError();
		waitState(ctrlSignalPkg::stError, 1'b0, 16);
		repeat (20) stepCycle(); // Must stay put with strobes low
		reset = 1'b1;
		repeat (8) stepCycle();
		reset = 1'b0;
	endtask

	initial begin
		clk      = 1'b0;
		reset    = 1'b1;
		inst     = '0;
		mioReady = 1'b0;
		lfsr     = 32'h180d_fd32;
		timeouts = 0;
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;

		// Illegal opcode, then an R-type word with an unused function code
		inst = {6'b111111, 26'(randBits(26))};
		holdInError();
		inst = {mipsIsaPkg::opRType, 20'(randBits(20)), 6'b111111};
		holdInError();

		for (int n = 0; n < 300; n++) begin
			inst = randomInstr(); // Held until the state is back in fetch
			waitState(ctrlSignalPkg::stFetch, 1'b1, 64);
			waitState(ctrlSignalPkg::stFetch, 1'b0, 64);
		end

		$display("Checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: mipsControl.f
source/mipsIsaPkg.sv
source/ctrlSignalPkg.sv
source/instrDecoder.sv
source/stateSequencer.sv
source/controlWordGen.sv
source/mipsControl.sv
verification/ctrlChecker.sv
verification/mipsControlTb.sv

// File: Makefile
# Verilator build for the multi-cycle MIPS control unit

VERILATOR ?= verilator
TOP       ?= mipsControlTb
FILELIST  ?= mipsControl.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= simv
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/$(SIM_BIN)

$(BUILD_DIR)/$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(SIM_BIN)

run: compile
	@out="$$($(BUILD_DIR)/$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
